// File: fetch_pkg.sv
// Fetch front end package with shared widths, types and FIFO constants
package fetch_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Memory word and byte address
  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;

  // Instruction container, compressed ones use the low half
  localparam int INSTR_W = 32;

  // Counter widths
  localparam int OUT_CNT_W   = 3;
  localparam int FLUSH_CNT_W = 2;
  localparam int STAT_CNT_W  = 16;

  //////////////////////////////
  // FIFO and request limits
  //////////////////////////////

  // Word slots in the alignment FIFO
  localparam int FIFO_DEPTH = 3;

  // Enough bits to count 0 to FIFO_DEPTH slots
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Requests in flight without a pending flush
  localparam int MAX_OUTSTANDING = 2;

  // Low bits that mark a full 32-bit instruction
  localparam logic [1:0] RVC_UNCOMPRESSED = 2'b11;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [INSTR_W-1:0]     instr_t;

  // Outstanding memory requests
  typedef logic [OUT_CNT_W-1:0]   out_cnt_t;

  // Responses still to be thrown away after a branch
  typedef logic [FLUSH_CNT_W-1:0] flush_cnt_t;

  // Wrapping statistics counter
  typedef logic [STAT_CNT_W-1:0]  stat_cnt_t;

  // Valid word slots in the FIFO
  typedef logic [FIFO_CNT_W-1:0]  fifo_cnt_t;

endpackage

// File: prefetch_ctrl.sv
`timescale 1ns/1ps
// Prefetch controller that issues word requests and drops responses flushed by a branch
module prefetch_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,

  // Core control
  input  logic                             branch_i,
  input  fetch_pkg::addr_t                 branch_addr_i,
  input  logic                             prefetch_en_i,

  // Memory request
  output logic                             fetch_valid_o,
  input  logic                             fetch_ready_i,
  output fetch_pkg::addr_t                 fetch_addr_o,

  // Memory response
  input  logic                             resp_valid_i,
  output logic                             resp_valid_gated_o,

  // Fill level of the alignment FIFO
  input  logic [fetch_pkg::FIFO_CNT_W-1:0] fifo_words_i,

  output logic                             busy_o
);

  import fetch_pkg::*;

  // Next word address to request
  addr_t      next_addr_q, next_addr_n;
  addr_t      branch_word;
  addr_t      addr_base;

  // Request and flush bookkeeping
  out_cnt_t   out_cnt_q, out_cnt_n;
  out_cnt_t   nonflush_cnt;
  out_cnt_t   fill_level;
  flush_cnt_t flush_cnt_q, flush_cnt_n;

  // Set by the first branch, nothing is fetched before it
  logic       started_q;

  logic       fifo_room;
  logic       branch_req;
  logic       req_accept;

  //////////////////////////////
  // Request side
  //////////////////////////////

  // Memory is word addressed
  assign branch_word = {branch_addr_i[ADDR_W-1:2], 2'b00};

  // Requests whose response will actually be used
  assign nonflush_cnt = out_cnt_q - out_cnt_t'(flush_cnt_q);

  // Words held plus words on their way
  assign fill_level = out_cnt_t'(fifo_words_i) + nonflush_cnt;

  // Keep one slot spare and cap requests in flight
  assign fifo_room = started_q &&
                     (fill_level < out_cnt_t'(FIFO_DEPTH - 1)) &&
                     (out_cnt_q < out_cnt_t'(MAX_OUTSTANDING));

  // Branch request goes out at once
  // Bounded so the flush count cannot overflow
  assign branch_req = prefetch_en_i && (out_cnt_q <= out_cnt_t'(MAX_OUTSTANDING));

  assign fetch_valid_o = branch_i ? branch_req : (prefetch_en_i && fifo_room);
  assign fetch_addr_o  = branch_i ? branch_word : next_addr_q;

  assign req_accept = fetch_valid_o && fetch_ready_i;

  // Address held while ready is low
  assign addr_base   = branch_i ? branch_word : next_addr_q;
  assign next_addr_n = req_accept ? (addr_base + addr_t'(4)) : addr_base;

  //////////////////////////////
  // Outstanding and flush
  //////////////////////////////

  // Up on accepted request, down on any response
  assign out_cnt_n = out_cnt_q + out_cnt_t'(req_accept) - out_cnt_t'(resp_valid_i);

  always_comb begin
    flush_cnt_n = flush_cnt_q;
    if (branch_i) begin
      // Every request still in flight now belongs to the old path
      // A response arriving this cycle is already gone
      flush_cnt_n = flush_cnt_t'(out_cnt_q - out_cnt_t'(resp_valid_i));
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      // One stale word dropped
      flush_cnt_n = flush_cnt_q - 1'b1;
    end
  end

  // Responses are in order so stale ones come first
  assign resp_valid_gated_o = resp_valid_i && (flush_cnt_q == '0);

  // Busy while any response is still expected
  assign busy_o = (out_cnt_q != '0);

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_addr_q <= '0;
      out_cnt_q   <= '0;
      flush_cnt_q <= '0;
      started_q   <= 1'b0;
    end else begin
      next_addr_q <= next_addr_n;
      out_cnt_q   <= out_cnt_n;
      flush_cnt_q <= flush_cnt_n;
      if (branch_i) begin
        started_q <= 1'b1;
      end
    end
  end

endmodule

// File: align_buffer.sv
`timescale 1ns/1ps
// Alignment buffer that rebuilds 16- and 32-bit instructions from a small word FIFO
module align_buffer (
  input  logic                             clk,
  input  logic                             rst_n,

  // Core control
  input  logic                             branch_i,
  input  fetch_pkg::addr_t                 branch_addr_i,

  // Filtered memory response
  input  logic                             resp_valid_i,
  input  fetch_pkg::word_t                 resp_rdata_i,

  // Instruction output
  output logic                             instr_valid_o,
  input  logic                             instr_ready_i,
  output fetch_pkg::instr_t                instr_o,
  output fetch_pkg::addr_t                 instr_addr_o,

  // Fill level back to the prefetcher
  output logic [fetch_pkg::FIFO_CNT_W-1:0] fifo_words_o
);

  import fetch_pkg::*;

  // Slot 0 is the oldest word and feeds the output
  word_t     slot_q    [FIFO_DEPTH];
  word_t     slot_push [FIFO_DEPTH];
  word_t     slot_n    [FIFO_DEPTH];

  // Valid slots are always 0 up to words_q-1
  fifo_cnt_t words_q, words_push, words_n;

  // Halfword address of the instruction at the output
  addr_t     addr_q, addr_n;

  // Candidate instruction data
  word_t     head;
  word_t     straddle;
  logic      head_valid;
  logic      straddle_valid;

  logic      lower_compr;
  logic      upper_compr;
  logic      instr_compr;
  logic      xfer;
  logic      pop;

  //////////////////////////////
  // Instruction select
  //////////////////////////////

  // Oldest word, or the incoming one when the FIFO is empty
  assign head       = (words_q != '0) ? slot_q[0] : resp_rdata_i;
  assign head_valid = (words_q != '0) || resp_valid_i;

  // Upper half of the head plus lower half of the following word
  assign straddle = (words_q > fifo_cnt_t'(1)) ?
                    {slot_q[1][15:0], head[31:16]} :
                    {resp_rdata_i[15:0], head[31:16]};

  // Second word from slot 1 or straight from memory
  assign straddle_valid = (words_q > fifo_cnt_t'(1)) ||
                          ((words_q != '0) && resp_valid_i);

  // Only meaningful while the head is valid
  assign lower_compr = (head[1:0] != RVC_UNCOMPRESSED);
  assign upper_compr = (head[17:16] != RVC_UNCOMPRESSED);

  always_comb begin
    // Aligned case, whole instruction starts in the head word
    instr_o       = head;
    instr_valid_o = head_valid;
    if (addr_q[1]) begin
      // Starts at the upper half
      instr_o = straddle;
      if (!upper_compr) begin
        // 32-bit one needs both halves present
        instr_valid_o = straddle_valid;
      end
    end
    // Old path content never leaves on a branch
    if (branch_i) begin
      instr_valid_o = 1'b0;
    end
  end

  assign instr_compr = addr_q[1] ? upper_compr : lower_compr;

  assign xfer = instr_valid_o && instr_ready_i;

  // Slot 0 is done when its upper half has been used
  assign pop = xfer && (addr_q[1] || !instr_compr);

  // Step 2 for compressed, 4 otherwise
  assign addr_n = xfer ? (addr_q + (instr_compr ? addr_t'(2) : addr_t'(4))) : addr_q;

  //////////////////////////////
  // FIFO update
  //////////////////////////////

  always_comb begin
    slot_push  = slot_q;
    words_push = words_q;
    // New word lands in the first free slot
    if (resp_valid_i && (words_q < fifo_cnt_t'(FIFO_DEPTH))) begin
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        if (fifo_cnt_t'(i) == words_q) begin
          slot_push[i] = resp_rdata_i;
        end
      end
      words_push = words_q + 1'b1;
    end
  end

  always_comb begin
    slot_n  = slot_push;
    words_n = words_push;
    // Shift down by one word
    // Pass-through words go in and out in the same cycle
    if (pop) begin
      for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
        slot_n[i] = slot_push[i + 1];
      end
      words_n = words_push - 1'b1;
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      words_q <= '0;
      addr_q  <= '0;
    end else if (branch_i) begin
      // Drop everything and restart at the target halfword
      // An unaligned target skips the lower half of its first word
      words_q <= '0;
      addr_q  <= {branch_addr_i[ADDR_W-1:1], 1'b0};
    end else begin
      words_q <= words_n;
      addr_q  <= addr_n;
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    slot_q <= slot_n;
  end

  assign instr_addr_o = addr_q;
  assign fifo_words_o = words_q;

endmodule

// File: fetch_stats.sv
`timescale 1ns/1ps
// Fetch statistics counting delivered instructions and miss cycles
module fetch_stats (
  input  logic                 clk,
  input  logic                 rst_n,

  // Observed handshakes
  input  logic                 instr_valid_i,
  input  logic                 instr_ready_i,
  input  logic                 resp_valid_i,
  input  logic                 branch_i,

  // Wrapping counters
  output fetch_pkg::stat_cnt_t instr_count_o,
  output fetch_pkg::stat_cnt_t miss_count_o
);

  import fetch_pkg::*;

  stat_cnt_t instr_cnt_q;
  stat_cnt_t miss_cnt_q;

  logic      delivered;
  logic      miss;

  // One instruction handed over
  assign delivered = instr_valid_i && instr_ready_i;

  // Consumer waiting with nothing to give
  // Branch cycles and cycles with a word arriving are not counted
  assign miss = instr_ready_i && !instr_valid_i && !branch_i && !resp_valid_i;

  //////////////////////////////
  // Counters
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_cnt_q <= '0;
      miss_cnt_q  <= '0;
    end else begin
      if (delivered) begin
        instr_cnt_q <= instr_cnt_q + 1'b1;
      end
      if (miss) begin
        miss_cnt_q <= miss_cnt_q + 1'b1;
      end
    end
  end

  assign instr_count_o = instr_cnt_q;
  assign miss_count_o  = miss_cnt_q;

endmodule

// File: fetch_unit_top.sv
`timescale 1ns/1ps
// Instruction fetch front end joining prefetcher, alignment buffer and statistics
module fetch_unit_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core control
  input  logic                 branch_i,
  input  fetch_pkg::addr_t     branch_addr_i,
  input  logic                 prefetch_en_i,
  output logic                 busy_o,

  // Memory request
  output logic                 fetch_valid_o,
  input  logic                 fetch_ready_i,
  output fetch_pkg::addr_t     fetch_addr_o,

  // Memory response
  input  logic                 resp_valid_i,
  input  fetch_pkg::word_t     resp_rdata_i,

  // Instruction output
  output logic                 instr_valid_o,
  input  logic                 instr_ready_i,
  output fetch_pkg::instr_t    instr_o,
  output fetch_pkg::addr_t     instr_addr_o,

  // Statistics
  output fetch_pkg::stat_cnt_t instr_count_o,
  output fetch_pkg::stat_cnt_t miss_count_o
);

  import fetch_pkg::*;

  // Response with stale words removed
  logic      resp_valid_gated;

  // FIFO fill level seen by the prefetcher
  fifo_cnt_t fifo_words;

  prefetch_ctrl prefetch_ctrl_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .branch_i           (branch_i),
    .branch_addr_i      (branch_addr_i),
    .prefetch_en_i      (prefetch_en_i),
    .fetch_valid_o      (fetch_valid_o),
    .fetch_ready_i      (fetch_ready_i),
    .fetch_addr_o       (fetch_addr_o),
    .resp_valid_i       (resp_valid_i),
    .resp_valid_gated_o (resp_valid_gated),
    .fifo_words_i       (fifo_words),
    .busy_o             (busy_o)
  );

  align_buffer align_buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .resp_valid_i  (resp_valid_gated),
    .resp_rdata_i  (resp_rdata_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .fifo_words_o  (fifo_words)
  );

  // Watches the output handshake and the filtered response
  fetch_stats fetch_stats_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .resp_valid_i  (resp_valid_gated),
    .branch_i      (branch_i),
    .instr_count_o (instr_count_o),
    .miss_count_o  (miss_count_o)
  );

endmodule

// File: tb_fetch_unit.sv
`timescale 1ns/1ps
// Testbench for the fetch front end with memory model, instruction walker and checks
module tb_fetch_unit;

  import fetch_pkg::*;

  localparam time PERIOD  = 100ns;
  // Branch count sits right after the 16-word image, events follow it
  localparam int  NBR_IDX = 16;
  localparam int  EV_BASE = 17;

  logic      clk;
  logic      rst_n;
  logic      branch_i;
  addr_t     branch_addr_i;
  logic      prefetch_en_i;
  logic      busy_o;
  logic      fetch_valid_o;
  logic      fetch_ready_i;
  addr_t     fetch_addr_o;
  logic      resp_valid_i;
  word_t     resp_rdata_i;
  logic      instr_valid_o;
  logic      instr_ready_i;
  instr_t    instr_o;
  addr_t     instr_addr_o;
  stat_cnt_t instr_count_o;
  stat_cnt_t miss_count_o;

  // Image, branch count and events from the stimulus file
  word_t       stim [0:63];
  logic [31:0] rng;
  int          cycle;
  int          errors;
  int          xfers;
  int          misses;
  int          total;
  logic        loaded;

  // Memory model, responses in request order
  addr_t resp_addr_q  [$];
  int    resp_due_q   [$];
  // Branch generation each request was issued in
  int    resp_epoch_q [$];
  int    epoch;

  // Walker position and values seen in a stalled cycle
  addr_t  walk_addr;
  logic   held_valid;
  logic   held_compr;
  instr_t held_instr;
  addr_t  held_addr;

  fetch_unit_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // LCG step, upper bits used for the value
  function automatic int unsigned rand_below(input int unsigned n);
    rng = rng * 32'd1103515245 + 32'd12345;
    return (rng >> 16) % n;
  endfunction

  // Image repeats every 64 bytes
  function automatic logic [15:0] mem_half(input addr_t a);
    word_t w;
    w = stim[a[5:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // Compressed ones only carry the low half
  task automatic check_instr(input string name, input instr_t got, input instr_t exp,
                             input logic compr);
    if ((compr && got[15:0] !== exp[15:0]) || (!compr && got !== exp)) begin
      $display("FAIL %s got %h expected %h at cycle %0d", name, got, exp, cycle);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h at cycle %0d", name, got, exp, cycle);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h at cycle %0d", name, got, exp, cycle);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input stat_cnt_t got, input stat_cnt_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////
  // One clock cycle
  //////////////////////////////

  task automatic run_cycle(input logic br, input addr_t br_addr, input logic rdy_on);
    logic [15:0] lo;
    logic        compr;
    logic        resp_live;
    @(posedge clk);
    #10;
    cycle++;
    branch_i      = br;
    branch_addr_i = br_addr;
    instr_ready_i = rdy_on && (rand_below(3) != 0);
    fetch_ready_i = (rand_below(4) != 0);
    resp_valid_i  = 1'b0;
    resp_live     = 1'b0;
    if ((resp_due_q.size() > 0) && (resp_due_q[0] <= cycle)) begin
      resp_valid_i = 1'b1;
      resp_rdata_i = stim[resp_addr_q.pop_front() >> 2 & 32'hF];
      void'(resp_due_q.pop_front());
      // Words requested before the latest branch are thrown away
      resp_live    = (resp_epoch_q.pop_front() == epoch);
    end
    // Sample late in the cycle where everything has settled
    #80;
    if (held_valid && !br) begin
      if (!instr_valid_o) begin
        $display("instr_valid_o dropped while stalled at cycle %0d", cycle);
        errors++;
      end
      check_instr("instr_o", instr_o, held_instr, held_compr);
      check_addr("instr_addr_o", instr_addr_o, held_addr);
    end
    // Instruction waiting at the output is the one at the walker position
    lo         = mem_half(walk_addr);
    held_compr = (lo[1:0] != RVC_UNCOMPRESSED);
    held_valid = instr_valid_o && !instr_ready_i;
    held_instr = instr_o;
    held_addr  = instr_addr_o;
    // Busy while any response is still on its way
    check_flag("busy_o", busy_o, (resp_due_q.size() != 0) || resp_valid_i);
    // Consumer waiting with nothing to give and no current word arriving
    if (instr_ready_i && !instr_valid_o && !br && !resp_live) begin
      misses++;
    end
    if (br) begin
      walk_addr = {br_addr[31:1], 1'b0};
      epoch++;
      if (instr_valid_o) begin
        $display("instr_valid_o high on a branch cycle %0d", cycle);
        errors++;
      end
      if (fetch_valid_o) begin
        check_addr("fetch_addr_o", fetch_addr_o, {br_addr[31:2], 2'b00});
      end
    end
    // Walker applies the RVC length rule
    if (instr_valid_o && instr_ready_i) begin
      lo    = mem_half(walk_addr);
      compr = (lo[1:0] != RVC_UNCOMPRESSED);
      check_instr("instr_o", instr_o, {mem_half(walk_addr + 2), lo}, compr);
      check_addr("instr_addr_o", instr_addr_o, walk_addr);
      walk_addr = walk_addr + (compr ? 2 : 4);
      xfers++;
    end
    // Answer 1 to 3 cycles later
    if (fetch_valid_o && fetch_ready_i) begin
      resp_addr_q.push_back(fetch_addr_o);
      resp_due_q.push_back(cycle + 1 + int'(rand_below(3)));
      resp_epoch_q.push_back(epoch);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int n_br;
    int k;
    int goal;
    rst_n         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    prefetch_en_i = 1'b1;
    fetch_ready_i = 1'b0;
    resp_valid_i  = 1'b0;
    resp_rdata_i  = '0;
    instr_ready_i = 1'b0;
    rng        = 32'd17;
    cycle      = 0;
    errors     = 0;
    xfers      = 0;
    misses     = 0;
    total      = 0;
    epoch      = 0;
    walk_addr  = '0;
    held_valid = 1'b0;
    held_compr = 1'b0;
    loaded     = 1'b0;
    $readmemh("fetch_stim.txt", stim);
    n_br = stim[NBR_IDX];
    for (k = 0; k < n_br; k++) begin
      total += stim[EV_BASE + 2 * k + 1];
    end
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    #10 rst_n = 1'b1;
    // Each branch, then its run of instructions
    for (k = 0; k < n_br; k++) begin
      goal = xfers + stim[EV_BASE + 2 * k + 1];
      run_cycle(1'b1, stim[EV_BASE + 2 * k], 1'b1);
      while (xfers < goal) begin
        run_cycle(1'b0, '0, 1'b1);
      end
    end
    // Let the counter catch up with the last transfer
    run_cycle(1'b0, '0, 1'b0);
    run_cycle(1'b0, '0, 1'b0);
    check_count("instr_count_o", instr_count_o, stat_cnt_t'(xfers));
    check_count("miss_count_o", miss_count_o, stat_cnt_t'(misses));
    $display("Errors %0d, instructions %0d of %0d, misses %0d",
             errors, xfers, total, misses);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the expected instruction count
  initial begin
    int limit;
    wait (loaded);
    limit = 40 * total + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, errors %0d, instructions %0d of %0d",
             limit, errors, xfers, total);
    $display("Test failed");
    $finish;
  end

endmodule

// File: fetch_stim.txt
// Hex values: first 16 are memory words at byte addresses 0x00 to 0x3C
// then the branch count, then per branch: target address, instructions before next branch
// Aligned 32-bit instructions
00100093
00200113
00308193
00418213
// Mixed 16 and 32-bit, some straddle word boundaries
02934505
808200a0
00c00313
05330505
458100b5
95324601
00d003b3
0e130001
470501c0
00e00413
00f00493
01000513
// Number of branch events
00000006
// Aligned stream, then mixed stream
00000000 00000004
00000010 0000000e
// Unaligned targets, the second starts with a straddling 32-bit one
00000016 00000005
0000002e 00000003
// Long runs under back-pressure, the last one wraps the image
00000004 00000006
00000022 00000014

// File: flist.f
fetch_pkg.sv
prefetch_ctrl.sv
align_buffer.sv
fetch_stats.sv
fetch_unit_top.sv
tb_fetch_unit.sv
